// File: hdl/fit_pkg.sv
// Shared widths, sample and total types, zone and intensity thresholds, status codes
package fit_pkg;

    // Clock and time keeping
    localparam int CLK_HZ   = 50_000_000;              // Default system clock rate
    localparam int TIME_W   = 6;                       // Width of seconds and minutes counters
    localparam int TIME_MAX = 59;                      // Last value before wrap

    typedef logic [TIME_W-1:0] time_t;                 // Seconds or minutes value

    // Sample inputs
    typedef logic [7:0] hr_t;                          // Heart rate in bpm
    typedef logic [2:0] steps_t;                       // Steps per second
    typedef logic [7:0] stride_t;                      // Stride length

    // Accumulated values
    typedef logic [15:0] steps_total_t;                // Running step total
    typedef logic [31:0] dist_t;                       // Distance, calories and HR sum
    typedef logic [7:0]  count_t;                      // Number of accepted samples
    typedef logic [15:0] speed_t;                      // Distance per sample

    // Heart rate zone
    localparam int HR_SAFE_MAX = 150;                  // Top of safe zone
    localparam int HR_WARN_MAX = 180;                  // Top of warning zone

    typedef logic [1:0] zone_t;                        // Zone status code

    localparam zone_t ZONE_SAFE  = 2'd0;
    localparam zone_t ZONE_WARN  = 2'd1;
    localparam zone_t ZONE_EMERG = 2'd2;

    // Workout intensity from the average heart rate
    localparam int INT_WARMUP_LT   = 120;              // Below this is warm-up
    localparam int INT_FATBURN_MAX = 160;              // Highest average still fat burn

    localparam logic [1:0] INT_WARMUP  = 2'd0;
    localparam logic [1:0] INT_FATBURN = 2'd1;
    localparam logic [1:0] INT_CARDIO  = 2'd2;

    // Heart rate trend against the previous sample
    localparam logic [1:0] TREND_SAME = 2'd0;
    localparam logic [1:0] TREND_UP   = 2'd1;
    localparam logic [1:0] TREND_DOWN = 2'd2;

    // Calorie estimate is CAL_MUL * count * avg_hr / CAL_DIV
    localparam int CAL_MUL = 15;
    localparam int CAL_DIV = 8000;

endpackage

// File: hdl/stopwatch.sv
// Stopwatch with one-second tick divider and wrapping seconds and minutes counters
module stopwatch #(
    parameter int ticks_per_sec = fit_pkg::CLK_HZ      // Clock cycles per second
) (
    input  logic          clk,
    input  logic          rst,
    output fit_pkg::time_t sec,                         // Seconds 0 to 59
    output fit_pkg::time_t min                          // Minutes 0 to 59
);
    import fit_pkg::*;

    // Divider width, at least one bit even for a degenerate divide by one
    localparam int CNT_W = (ticks_per_sec > 1) ? $clog2(ticks_per_sec) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(ticks_per_sec - 1);

    logic [CNT_W-1:0] cyc_cnt;                         // Cycles within the current second
    logic             tick;                            // One-cycle pulse per second
    logic             sec_wrap;                        // Seconds at last value

    // Cycle divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cyc_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (cyc_cnt == CNT_LAST) begin
                cyc_cnt <= '0;                         // Second complete
                tick    <= 1'b1;
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

    assign sec_wrap = (sec == time_t'(TIME_MAX));

    // Seconds counter advances the cycle after the tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sec <= '0;
        end else if (tick) begin
            if (sec_wrap)
                sec <= '0;                             // 59 rolls to 0
            else
                sec <= sec + 1'b1;
        end
    end

    // Minutes counter carries from the seconds wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            min <= '0;
        end else if (tick && sec_wrap) begin
            if (min == time_t'(TIME_MAX))
                min <= '0;                             // Hour boundary
            else
                min <= min + 1'b1;
        end
    end

endmodule

// File: hdl/activity_accum.sv
// Per-sample accumulator for steps, distance, heart rate statistics, calories and speed
module activity_accum (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_in,        // One-cycle sample strobe
    input  fit_pkg::hr_t          hr_in,           // Heart rate of this sample
    input  fit_pkg::steps_t       steps_in,        // Steps in this second
    input  fit_pkg::stride_t      stride_in,       // Stride length
    output fit_pkg::steps_total_t total_steps,
    output fit_pkg::dist_t        total_dist,
    output fit_pkg::dist_t        dist_per_sec,    // Distance of the last sample
    output fit_pkg::count_t       elapsed,         // Samples accepted so far
    output fit_pkg::hr_t          max_hr,
    output fit_pkg::dist_t        avg_hr,          // Includes the latest sample
    output fit_pkg::dist_t        calories,
    output fit_pkg::speed_t       speed
);
    import fit_pkg::*;

    dist_t        hr_sum;                          // Running heart rate sum

    count_t       cnt_next;                        // Count including this sample
    dist_t        cnt_wide;                        // Count as divisor width
    dist_t        sum_next;
    dist_t        dist_step;                       // Steps times stride
    dist_t        dist_next;
    dist_t        avg_next;
    dist_t        cal_next;
    speed_t       speed_next;
    steps_total_t steps_next;
    hr_t          max_next;

    // Next values for a valid sample
    always_comb begin
        cnt_next   = elapsed + 1'b1;
        cnt_wide   = dist_t'(cnt_next);
        sum_next   = hr_sum + dist_t'(hr_in);
        dist_step  = dist_t'(steps_in) * dist_t'(stride_in);
        dist_next  = total_dist + dist_step;
        steps_next = total_steps + steps_total_t'(steps_in);
        max_next   = (hr_in > max_hr) ? hr_in : max_hr;

        // Divisions need a nonzero count; zero only after the count overflows
        if (cnt_wide != '0) begin
            avg_next   = sum_next / cnt_wide;
            speed_next = speed_t'(dist_next / cnt_wide);
        end else begin
            avg_next   = '0;
            speed_next = '0;
        end

        cal_next = (dist_t'(CAL_MUL) * cnt_wide * avg_next) / dist_t'(CAL_DIV);
    end

    // Totals and counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            total_steps  <= '0;
            total_dist   <= '0;
            dist_per_sec <= '0;
            elapsed      <= '0;
            hr_sum       <= '0;
        end else if (valid_in) begin
            total_steps  <= steps_next;
            total_dist   <= dist_next;
            dist_per_sec <= dist_step;                 // Only this sample
            elapsed      <= cnt_next;
            hr_sum       <= sum_next;
        end
    end

    // Heart rate statistics and derived figures
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            max_hr   <= '0;
            avg_hr   <= '0;
            calories <= '0;
            speed    <= '0;
        end else if (valid_in) begin
            max_hr   <= max_next;
            avg_hr   <= avg_next;                      // No lag behind the sum
            calories <= cal_next;
            speed    <= speed_next;
        end
    end

endmodule

// File: hdl/hr_status.sv
// Heart rate zone, workout intensity, heart rate trend and step feedback
module hr_status (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,             // One-cycle sample strobe
    input  fit_pkg::hr_t     hr_in,
    input  fit_pkg::steps_t  steps_in,
    input  fit_pkg::dist_t   avg_hr,               // From the accumulator
    output fit_pkg::zone_t   hr_zone,
    output logic [1:0]       intensity,            // Follows avg_hr directly
    output logic [1:0]       hr_trend,
    output logic             step_good             // Steps held or improved
);
    import fit_pkg::*;

    hr_t    prev_hr;                               // Last accepted heart rate
    steps_t prev_steps;                            // Last accepted step rate
    zone_t  zone_next;
    logic [1:0] trend_next;

    // Zone and trend decode of the incoming sample
    always_comb begin
        if (hr_in <= hr_t'(HR_SAFE_MAX))
            zone_next = ZONE_SAFE;
        else if (hr_in <= hr_t'(HR_WARN_MAX))
            zone_next = ZONE_WARN;
        else
            zone_next = ZONE_EMERG;

        if (hr_in > prev_hr)
            trend_next = TREND_UP;
        else if (hr_in < prev_hr)
            trend_next = TREND_DOWN;
        else
            trend_next = TREND_SAME;                   // Equal to last sample
    end

    // Registered status and history
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hr_zone    <= ZONE_SAFE;
            hr_trend   <= TREND_SAME;
            step_good  <= 1'b0;
            prev_hr    <= '0;
            prev_steps <= '0;
        end else if (valid_in) begin
            hr_zone    <= zone_next;
            hr_trend   <= trend_next;
            step_good  <= (steps_in >= prev_steps);
            prev_hr    <= hr_in;
            prev_steps <= steps_in;
        end
    end

    // Intensity band from the running average
    always_comb begin
        if (avg_hr < dist_t'(INT_WARMUP_LT))
            intensity = INT_WARMUP;
        else if (avg_hr <= dist_t'(INT_FATBURN_MAX))
            intensity = INT_FATBURN;                   // 160 still counts here
        else
            intensity = INT_CARDIO;
    end

endmodule

// File: hdl/fitness_tracker.sv
// Tracker top level joining the stopwatch, activity accumulator and heart rate status
module fitness_tracker #(
    parameter int ticks_per_sec = fit_pkg::CLK_HZ  // Cycles per stopwatch second
) (
    input  logic                  clk,
    input  logic                  rst,

    // Sample interface
    input  logic                  valid_in,
    input  fit_pkg::hr_t          hr_in,
    input  fit_pkg::steps_t       steps_in,
    input  fit_pkg::stride_t      stride_in,

    // Stopwatch
    output fit_pkg::time_t        sec,
    output fit_pkg::time_t        min,

    // Activity totals
    output fit_pkg::steps_total_t total_steps,
    output fit_pkg::dist_t        total_dist,
    output fit_pkg::dist_t        dist_per_sec,
    output fit_pkg::count_t       elapsed,
    output fit_pkg::hr_t          max_hr,
    output fit_pkg::dist_t        avg_hr,          // Also feeds the intensity decode
    output fit_pkg::dist_t        calories,
    output fit_pkg::speed_t       speed,

    // Status
    output fit_pkg::zone_t        hr_zone,
    output logic [1:0]            intensity,
    output logic [1:0]            hr_trend,
    output logic                  step_good
);

    // Free-running time base
    stopwatch #(
        .ticks_per_sec (ticks_per_sec)
    ) u_stopwatch (
        .clk (clk),
        .rst (rst),
        .sec (sec),
        .min (min)
    );

    // Sample accumulation
    activity_accum u_accum (
        .clk          (clk),
        .rst          (rst),
        .valid_in     (valid_in),
        .hr_in        (hr_in),
        .steps_in     (steps_in),
        .stride_in    (stride_in),
        .total_steps  (total_steps),
        .total_dist   (total_dist),
        .dist_per_sec (dist_per_sec),
        .elapsed      (elapsed),
        .max_hr       (max_hr),
        .avg_hr       (avg_hr),
        .calories     (calories),
        .speed        (speed)
    );

    // Zone, trend, steps and intensity
    hr_status u_status (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .hr_in     (hr_in),
        .steps_in  (steps_in),
        .avg_hr    (avg_hr),                       // Registered average from u_accum
        .hr_zone   (hr_zone),
        .intensity (intensity),
        .hr_trend  (hr_trend),
        .step_good (step_good)
    );

endmodule

// File: test/fitness_tracker_assert.sv
// Bound assertions on stopwatch ranges, step total growth and stopwatch isolation from samples
module fitness_tracker_assert (
    input logic                  clk,
    input logic                  rst,
    input logic                  valid_in,
    input logic                  tick,                // Stopwatch one-second pulse
    input fit_pkg::time_t        sec,
    input fit_pkg::time_t        min,
    input fit_pkg::steps_total_t total_steps
);
    timeunit 1ns;
    timeprecision 1ps;

    import fit_pkg::*;

    int unsigned fail_count = 0;                     // Failed assertions so far

    // Counters stay inside 0 to 59
    a_time_range: assert property (@(posedge clk) disable iff (rst)
        (sec <= time_t'(TIME_MAX)) && (min <= time_t'(TIME_MAX)))
        else begin
            fail_count++;
            $error("stopwatch out of range at %0d:%0d", min, sec);
        end

    // Step total only grows between resets
    a_steps_grow: assert property (@(posedge clk) disable iff (rst)
        total_steps >= $past(total_steps))
        else begin
            fail_count++;
            $error("total_steps fell from %0d to %0d", $past(total_steps), total_steps);
        end

    // A sample away from a tick leaves the stopwatch untouched
    a_sample_hold: assert property (@(posedge clk) disable iff (rst)
        valid_in && !tick |=> $stable(sec) && $stable(min))
        else begin
            fail_count++;
            $error("stopwatch moved to %0d:%0d on a sample without a tick", min, sec);
        end

    // A sample on a tick gives only the normal one-step advance of seconds
    a_sample_sec: assert property (@(posedge clk) disable iff (rst)
        valid_in && tick |=>
            (sec == (($past(sec) == time_t'(TIME_MAX)) ? time_t'(0) : $past(sec) + 1'b1)))
        else begin
            fail_count++;
            $error("seconds jumped to %0d after a sample", sec);
        end

    // Minutes move only on the seconds wrap
    a_sample_min: assert property (@(posedge clk) disable iff (rst)
        valid_in && tick && (sec != time_t'(TIME_MAX)) |=> $stable(min))
        else begin
            fail_count++;
            $error("minutes changed to %0d after a sample", min);
        end

endmodule

bind fitness_tracker fitness_tracker_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .valid_in    (valid_in),
    .tick        (u_stopwatch.tick),
    .sec         (sec),
    .min         (min),
    .total_steps (total_steps)
);

// File: test/tb_fitness_tracker.sv
// Testbench for the fitness tracker with reference model, output comparison and watchdog
module tb_fitness_tracker;
    timeunit 1ns;
    timeprecision 1ps;

    import fit_pkg::*;

    localparam int TPS        = 10;                   // Stopwatch divider under test
    localparam int SW_SECS    = 65;                   // Runs past the seconds wrap
    localparam int N_RAND     = 200;                  // Random samples
    localparam int MAX_GAP    = 3;                    // Idle cycles after a sample
    localparam int INT_RUN    = 3;                    // Samples per intensity run
    localparam int N_DIRECTED = 8 + 4 * INT_RUN;      // Zone, trend and intensity samples
    localparam int N_RESETS   = 6;
    localparam int RUN_CYCLES = (N_RAND + N_DIRECTED) * (MAX_GAP + 1) + SW_SECS * TPS
                                + N_RESETS * 8;
    localparam int TIMEOUT_NS = RUN_CYCLES * 10 * 2;  // Twice the expected run at 10 ns

    logic                clk;
    logic                rst;
    logic                valid_in;
    hr_t                 hr_in;
    steps_t              steps_in;
    stride_t             stride_in;
    time_t               sec;
    time_t               min;
    steps_total_t        total_steps;
    dist_t               total_dist;
    dist_t               dist_per_sec;
    count_t              elapsed;
    hr_t                 max_hr;
    dist_t               avg_hr;
    dist_t               calories;
    speed_t              speed;
    zone_t               hr_zone;
    logic [1:0]          intensity;
    logic [1:0]          hr_trend;
    logic                step_good;

    int unsigned m_steps, m_dist, m_dps, m_cnt, m_max;      // Model totals
    int unsigned m_sum, m_avg, m_cal, m_speed;
    int unsigned m_zone, m_trend, m_good;                   // Model status
    int unsigned m_prev_hr, m_prev_steps;                   // Last accepted sample

    int    n_checks  = 0;
    int    n_errors  = 0;
    string test_name = "reset";                       // Group running now

    fitness_tracker #(
        .ticks_per_sec (TPS)
    ) DUT (.*);

    always #5 clk = ~clk;                             // 10 ns period

    function automatic logic [1:0] intensity_of(input int unsigned avg);
        if (avg < INT_WARMUP_LT)
            return INT_WARMUP;
        else if (avg <= INT_FATBURN_MAX)
            return INT_FATBURN;                       // 160 still fat burn
        else
            return INT_CARDIO;
    endfunction

    function automatic void model_clear();
        m_steps      = 0;
        m_dist       = 0;
        m_dps        = 0;
        m_cnt        = 0;
        m_max        = 0;
        m_sum        = 0;
        m_avg        = 0;
        m_cal        = 0;
        m_speed      = 0;
        m_zone       = ZONE_SAFE;
        m_trend      = TREND_SAME;
        m_good       = 0;
        m_prev_hr    = 0;
        m_prev_steps = 0;
    endfunction

    // Reference update for one accepted sample
    function automatic void model_apply(input int unsigned hr, input int unsigned st,
                                        input int unsigned sd);
        m_cnt   = m_cnt + 1;
        m_sum   = m_sum + hr;                         // Sum includes this sample
        m_steps = (m_steps + st) % 65536;
        m_dps   = st * sd;
        m_dist  = m_dist + m_dps;
        if (hr > m_max)
            m_max = hr;
        m_avg   = m_sum / m_cnt;
        m_cal   = CAL_MUL * m_cnt * m_avg / CAL_DIV;
        m_speed = (m_dist / m_cnt) % 65536;           // 16-bit speed
        if (hr <= HR_SAFE_MAX)
            m_zone = ZONE_SAFE;
        else if (hr <= HR_WARN_MAX)
            m_zone = ZONE_WARN;
        else
            m_zone = ZONE_EMERG;
        if (hr > m_prev_hr)
            m_trend = TREND_UP;
        else if (hr < m_prev_hr)
            m_trend = TREND_DOWN;
        else
            m_trend = TREND_SAME;
        m_good       = (st >= m_prev_steps) ? 1 : 0;
        m_prev_hr    = hr;
        m_prev_steps = st;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        n_errors++;
        $display("error %s: %s expected %0d actual %0d", test_name, sig, exp, act);
    endtask

    task automatic check_outputs();
        n_checks++;
        if (total_steps !== m_steps)
            report_mismatch("total_steps", m_steps, total_steps);
        if (total_dist !== m_dist)
            report_mismatch("total_dist", m_dist, total_dist);
        if (dist_per_sec !== m_dps)
            report_mismatch("dist_per_sec", m_dps, dist_per_sec);
        if (elapsed !== m_cnt)
            report_mismatch("elapsed", m_cnt, elapsed);
        if (max_hr !== m_max)
            report_mismatch("max_hr", m_max, max_hr);
        if (avg_hr !== m_avg)
            report_mismatch("avg_hr", m_avg, avg_hr);
        if (calories !== m_cal)
            report_mismatch("calories", m_cal, calories);
        if (speed !== m_speed)
            report_mismatch("speed", m_speed, speed);
        if (hr_zone !== m_zone)
            report_mismatch("hr_zone", m_zone, hr_zone);
        if (hr_trend !== m_trend)
            report_mismatch("hr_trend", m_trend, hr_trend);
        if (step_good !== m_good)
            report_mismatch("step_good", m_good, step_good);
        if (intensity !== intensity_of(m_avg))
            report_mismatch("intensity", intensity_of(m_avg), intensity);
    endtask

    task automatic check_idle();
        if (sec !== '0)
            report_mismatch("sec", 0, sec);
        if (min !== '0)
            report_mismatch("min", 0, min);
        if ({total_steps, total_dist, dist_per_sec, elapsed, max_hr, avg_hr, calories, speed,
             hr_zone, intensity, hr_trend, step_good} !== '0) begin
            n_errors++;
            $display("reset did not clear the activity and status outputs");
        end
    endtask

    // Called right after a rising edge
    task automatic send_sample(input hr_t hr, input steps_t st, input stride_t sd, input int gap);
        valid_in  <= 1'b1;
        hr_in     <= hr;
        steps_in  <= st;
        stride_in <= sd;
        @(posedge clk);                               // DUT takes the sample here
        valid_in  <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);                               // Pending compare finishes first
        test_name = "reset";
        rst      <= 1'b1;
        valid_in <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        model_clear();
        @(negedge clk);
        check_idle();
        @(posedge clk);
    endtask

    // Model update on each strobe and compare at the falling edge
    always @(posedge clk) begin
        if (!rst && valid_in)
            model_apply(hr_in, steps_in, stride_in);
        @(negedge clk);
        if (!rst)
            check_outputs();
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        hr_t        hr;
        steps_t     st;
        stride_t    sd;
        hr_t        int_level  [4];
        logic [1:0] int_expect [4];
        int_level  = '{8'd119, 8'd120, 8'd160, 8'd161};
        int_expect = '{INT_WARMUP, INT_FATBURN, INT_FATBURN, INT_CARDIO};
        clk       = 1'b0;
        rst       = 1'b1;
        valid_in  = 1'b0;
        hr_in     = '0;
        steps_in  = '0;
        stride_in = '0;
        void'($urandom(68));
        model_clear();
        apply_reset();                                // Ends one edge after release

        test_name = "stopwatch";
        for (int n = 1; n <= SW_SECS; n++) begin
            repeat (TPS) @(posedge clk);
            @(negedge clk);
            if (sec !== time_t'(n % (TIME_MAX + 1)))
                report_mismatch("sec", n % (TIME_MAX + 1), sec);
            if (min !== time_t'(n / (TIME_MAX + 1)))
                report_mismatch("min", n / (TIME_MAX + 1), min);
        end
        @(posedge clk);

        test_name = "accumulate";
        for (int i = 0; i < N_RAND; i++) begin
            hr = hr_t'($urandom_range(220, 40));      // Spans all zones
            st = steps_t'($urandom_range(7, 0));
            sd = stride_t'($urandom_range(255, 0));
            send_sample(hr, st, sd, int'($urandom_range(MAX_GAP, 0)));
        end

        apply_reset();
        test_name = "zone";
        send_sample(8'd150, 3'd3, 8'd50, 0);
        send_sample(8'd151, 3'd3, 8'd50, 0);          // Equal steps
        send_sample(8'd180, 3'd2, 8'd50, 0);
        send_sample(8'd181, 3'd5, 8'd50, 0);
        @(posedge clk);
        test_name = "trend";
        send_sample(8'd181, 3'd5, 8'd60, 0);          // Same heart rate
        send_sample(8'd190, 3'd4, 8'd60, 0);
        send_sample(8'd100, 3'd4, 8'd60, 0);
        send_sample(8'd100, 3'd1, 8'd60, 0);
        @(posedge clk);

        for (int i = 0; i < 4; i++) begin
            apply_reset();
            test_name = "intensity";
            repeat (INT_RUN) send_sample(int_level[i], 3'd1, 8'd10, 0);
            @(negedge clk);
            if (intensity !== int_expect[i])
                report_mismatch("intensity level", int_expect[i], intensity);
        end

        repeat (2) @(posedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
                 DUT.u_assert.fail_count);
        if (n_errors == 0 && DUT.u_assert.fail_count == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: tb.f
hdl/fit_pkg.sv
hdl/stopwatch.sv
hdl/activity_accum.sv
hdl/hr_status.sv
hdl/fitness_tracker.sv
test/fitness_tracker_assert.sv
test/tb_fitness_tracker.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fitness tracker testbench with Verilator, run it and judge the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_fitness_tracker
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module "$TOP" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/V"$TOP" +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "=== PASS ===" "$SIM_LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
